// ==== design/cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    ////////////////////
    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct field, only meaningful under op_special
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_form_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_form_t;

    // same 32 bits, two field layouts
    typedef union packed {
        r_form_t r;
        i_form_t i;
    } instr_u;

endpackage

`default_nettype wire

// ==== design/cpu_pipe_pkg.sv ====
`default_nettype none

package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_lui
    } alu_op_t;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        alu_op_t  alu_op;
        word_t    pc;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dest;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;        // already extended or shifted for lui
        logic     use_imm;
        logic     is_load;
        logic     is_store;
        logic     reg_write;
        logic     is_branch;
        logic     branch_ne;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    result;
        word_t    store_data;
        reg_idx_t dest;
        logic     reg_write;
        logic     is_load;
        logic     is_store;
    } ex_mem_t;

    // writeback record, also the debug view
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t dest;
        word_t    data;
        logic     reg_write;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== design/decode_stage.sv ====
`default_nettype none

module decode_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  if_id_t    if_id,
    input  redirect_t redirect,
    input  word_t     rs_data,
    input  word_t     rt_data,
    output reg_idx_t  rs_addr,
    output reg_idx_t  rt_addr,
    output logic      stall,
    output id_ex_t    id_ex
);

    instr_u   instr;
    logic     known;
    alu_op_t  alu_op;
    word_t    imm_ext;
    logic     use_imm;
    logic     is_load;
    logic     is_store;
    logic     reg_write;
    logic     is_branch;
    logic     branch_ne;
    logic     dest_rd;
    reg_idx_t dest;

    assign instr   = if_id.instr;
    assign rs_addr = instr.r.rs;
    assign rt_addr = instr.r.rt;
    assign dest    = dest_rd ? instr.r.rd : instr.i.rt;

    ////////////////////
    // control decode
    always_comb begin
        known     = 1'b1;
        alu_op    = alu_add;
        imm_ext   = {{16{instr.i.imm[15]}}, instr.i.imm};   // sign by default
        use_imm   = 1'b1;
        is_load   = 1'b0;
        is_store  = 1'b0;
        reg_write = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        dest_rd   = 1'b0;
        case (instr.r.opcode)
            op_special: begin
                use_imm   = 1'b0;
                reg_write = 1'b1;
                dest_rd   = 1'b1;
                case (instr.r.funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    default: known  = 1'b0;
                endcase
            end
            op_addiu: reg_write = 1'b1;
            op_andi: begin
                alu_op    = alu_and;
                imm_ext   = {16'b0, instr.i.imm};
                reg_write = 1'b1;
            end
            op_ori: begin
                alu_op    = alu_or;
                imm_ext   = {16'b0, instr.i.imm};
                reg_write = 1'b1;
            end
            op_lui: begin
                alu_op    = alu_lui;
                imm_ext   = {instr.i.imm, 16'b0};
                reg_write = 1'b1;
            end
            op_lw: begin
                is_load   = 1'b1;
                reg_write = 1'b1;
            end
            op_sw:  is_store = 1'b1;
            op_beq: is_branch = 1'b1;
            op_bne: begin
                is_branch = 1'b1;
                branch_ne = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    // load in ID/EX feeding the word in IF/ID
    assign stall = id_ex.valid && id_ex.is_load && if_id.valid &&
                   (id_ex.dest == instr.r.rs || id_ex.dest == instr.r.rt);

    ////////////////////
    // ID/EX register
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            id_ex <= '0;
        end else begin
            id_ex.valid     <= if_id.valid && known && !stall && !redirect.taken;
            id_ex.alu_op    <= alu_op;
            id_ex.pc        <= if_id.pc;
            id_ex.rs        <= instr.r.rs;
            id_ex.rt        <= instr.r.rt;
            id_ex.dest      <= dest;
            id_ex.rs_val    <= rs_data;
            id_ex.rt_val    <= rt_data;
            id_ex.imm       <= imm_ext;
            id_ex.use_imm   <= use_imm;
            id_ex.is_load   <= is_load;
            id_ex.is_store  <= is_store;
            id_ex.reg_write <= reg_write && known;
            id_ex.is_branch <= is_branch;
            id_ex.branch_ne <= branch_ne;
        end
    end

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`default_nettype none

module execute_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  id_ex_t    id_ex,
    input  wb_t       wb,
    output ex_mem_t   ex_mem,
    output redirect_t redirect
);

    word_t op_a;
    word_t op_rt;
    word_t op_b;
    word_t alu_out;

    // mem stage first, load results only come back through wb
    function automatic word_t forward(reg_idx_t idx, word_t rf_val, ex_mem_t em, wb_t w);
        if (idx == '0)
            return '0;
        if (em.valid && em.reg_write && !em.is_load && em.dest == idx)
            return em.result;
        if (w.valid && w.reg_write && w.dest == idx)
            return w.data;
        return rf_val;
    endfunction

    assign op_a  = forward(id_ex.rs, id_ex.rs_val, ex_mem, wb);
    assign op_rt = forward(id_ex.rt, id_ex.rt_val, ex_mem, wb);
    assign op_b  = id_ex.use_imm ? id_ex.imm : op_rt;

    ////////////////////
    // alu
    always_comb begin
        case (id_ex.alu_op)
            alu_add:  alu_out = op_a + op_b;   // wraps
            alu_sub:  alu_out = op_a - op_b;
            alu_and:  alu_out = op_a & op_b;
            alu_or:   alu_out = op_a | op_b;
            alu_xor:  alu_out = op_a ^ op_b;
            alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {31'b0, op_a < op_b};
            alu_lui:  alu_out = op_b;
            default:  alu_out = '0;
        endcase
    end

    // beq/bne resolve here, no delay slot
    assign redirect.taken  = id_ex.valid && id_ex.is_branch &&
                             ((op_a == op_rt) != id_ex.branch_ne);
    assign redirect.target = id_ex.pc + 32'd4 + {id_ex.imm[29:0], 2'b00};

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.pc         <= id_ex.pc;
            ex_mem.result     <= alu_out;
            ex_mem.store_data <= op_rt;
            ex_mem.dest       <= id_ex.dest;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.is_load    <= id_ex.is_load;
            ex_mem.is_store   <= id_ex.is_store;
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
`default_nettype none

module fetch_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; #(
    parameter word_t reset_pc = 32'hbfc00000
) (
    input  logic      clk,
    input  logic      resetn,
    input  logic      stall,
    input  redirect_t redirect,
    input  word_t     inst_sram_rdata,
    output word_t     inst_sram_addr,
    output if_id_t    if_id
);

    word_t pc;
    logic  if_valid;
    word_t if_pc;       // pc that requested the word now on rdata
    logic  held_valid;
    word_t held_inst;

    assign inst_sram_addr = pc;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pc         <= reset_pc;
            if_valid   <= 1'b0;
            held_valid <= 1'b0;
        end else if (redirect.taken) begin
            pc         <= redirect.target;
            if_valid   <= 1'b0;   // word in flight is squashed
            held_valid <= 1'b0;
        end else if (stall) begin
            held_valid <= 1'b1;   // pc and if_valid freeze
        end else begin
            pc         <= pc + 32'd4;
            if_valid   <= 1'b1;
            held_valid <= 1'b0;
        end
    end

    // sram keeps reading pc during a stall, so the stalled word is kept here
    always_ff @(posedge clk) begin
        if (!stall || redirect.taken)
            if_pc <= pc;
        if (stall)
            held_inst <= if_id.instr;
    end

    assign if_id.valid = if_valid;
    assign if_id.pc    = if_pc;
    assign if_id.instr = held_valid ? held_inst : inst_sram_rdata;

endmodule

`default_nettype wire

// ==== design/memory_stage.sv ====
`default_nettype none

module memory_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  ex_mem_t    ex_mem,
    input  word_t      data_sram_rdata,
    output logic [3:0] data_sram_wen,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    output wb_t        wb,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic     wb_valid;
    logic     wb_reg_write;
    logic     wb_is_load;
    word_t    wb_pc;
    reg_idx_t wb_dest;
    word_t    wb_result;

    // data sram straight off ex_mem, top three address bits dropped
    assign data_sram_wen   = (ex_mem.valid && ex_mem.is_store) ? 4'b1111 : 4'b0000;
    assign data_sram_addr  = {3'b000, ex_mem.result[28:0]};
    assign data_sram_wdata = ex_mem.store_data;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
            wb_is_load   <= 1'b0;
        end else begin
            wb_valid     <= ex_mem.valid;
            wb_reg_write <= ex_mem.reg_write;
            wb_is_load   <= ex_mem.is_load;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc     <= ex_mem.pc;
        wb_dest   <= ex_mem.dest;
        wb_result <= ex_mem.result;
    end

    ////////////////////
    // writeback record, load data lands this cycle
    assign wb.valid     = wb_valid;
    assign wb.pc        = wb_pc;
    assign wb.dest      = wb_dest;
    assign wb.data      = wb_is_load ? data_sram_rdata : wb_result;
    assign wb.reg_write = wb_reg_write;

    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_wen   = (wb.valid && wb.reg_write && wb.dest != '0) ? 4'b1111 : 4'b0000;
    assign debug_wb_rf_wnum  = wb.dest;
    assign debug_wb_rf_wdata = wb.data;

endmodule

`default_nettype wire

// ==== design/mips_core.sv ====
`default_nettype none

module mips_core import cpu_isa_pkg::*, cpu_pipe_pkg::*; #(
    parameter word_t reset_pc = 32'hbfc00000
) (
    input  logic       clk,
    input  logic       resetn,
    input  word_t      inst_sram_rdata,
    input  word_t      data_sram_rdata,
    output word_t      inst_sram_addr,
    output logic [3:0] data_sram_wen,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_t       wb;
    redirect_t redirect;
    logic      stall;
    reg_idx_t  rs_addr;
    reg_idx_t  rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    fetch_stage #(.reset_pc(reset_pc)) fetch_inst (
        .clk(clk), .resetn(resetn), .stall(stall), .redirect(redirect),
        .inst_sram_rdata(inst_sram_rdata), .inst_sram_addr(inst_sram_addr),
        .if_id(if_id)
    );

    decode_stage decode_inst (
        .clk(clk), .resetn(resetn), .if_id(if_id), .redirect(redirect),
        .rs_data(rs_data), .rt_data(rt_data), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .stall(stall), .id_ex(id_ex)
    );

    register_file regfile_inst (
        .clk(clk), .resetn(resetn), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .wb(wb), .rs_data(rs_data), .rt_data(rt_data)
    );

    execute_stage execute_inst (
        .clk(clk), .resetn(resetn), .id_ex(id_ex), .wb(wb),
        .ex_mem(ex_mem), .redirect(redirect)
    );

    memory_stage memory_inst (
        .clk(clk), .resetn(resetn), .ex_mem(ex_mem), .data_sram_rdata(data_sram_rdata),
        .data_sram_wen(data_sram_wen), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .wb(wb),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`default_nettype none

module register_file import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  reg_idx_t rs_addr,
    input  reg_idx_t rt_addr,
    input  wb_t      wb,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [32];
    logic  wr_en;

    assign wr_en = wb.valid && wb.reg_write && (wb.dest != '0);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // r0 hardwired, same-cycle write seen by decode
    assign rs_data = (rs_addr == '0) ? '0 :
                     (wr_en && wb.dest == rs_addr) ? wb.data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (wr_en && wb.dest == rt_addr) ? wb.data : regs[rt_addr];

endmodule

`default_nettype wire

// ==== mips_core.f ====
design/cpu_isa_pkg.sv
design/cpu_pipe_pkg.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_core.sv
tests/clock_gen.sv
tests/mips_core_assertions.sv
tests/tb_mips_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mips_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_mips_core --Mdir obj_dir -o tb_mips_core -f mips_core.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_mips_core > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0

// ==== tests/clock_gen.sv ====
`default_nettype none

module clock_gen #(
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic resetn
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // reset held low, released on a rising edge
    initial begin
        resetn <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/mips_core_assertions.sv ====
`default_nettype none

module mips_core_assertions import cpu_isa_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  word_t      inst_sram_addr,
    input  logic [3:0] data_sram_wen,
    input  logic [3:0] debug_wb_rf_wen,
    input  reg_idx_t   debug_wb_rf_wnum
);

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////
    // byte enables are whole words only
    rf_wen_whole: assert property (@(posedge clk) disable iff (!resetn)
        debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf)
        else $error("debug_wb_rf_wen partial: %h", debug_wb_rf_wen);

    data_wen_whole: assert property (@(posedge clk) disable iff (!resetn)
        data_sram_wen == 4'h0 || data_sram_wen == 4'hf)
        else $error("data_sram_wen partial: %h", data_sram_wen);

    no_r0_write: assert property (@(posedge clk) disable iff (!resetn)
        debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != 5'd0)
        else $error("register 0 reported as written");

    fetch_aligned: assert property (@(posedge clk) disable iff (!resetn)
        inst_sram_addr[1:0] == 2'b00)
        else $error("inst_sram_addr not word aligned: %h", inst_sram_addr);

    // nothing leaves the core while reset is held
    quiet_in_reset: assert property (@(posedge clk)
        !resetn |-> (data_sram_wen == 4'h0 && debug_wb_rf_wen == 4'h0))
        else $error("write enable active during reset");

endmodule

`default_nettype wire

// ==== tests/program_stimulus.hex ====
// @000 program words, @040 initial data words, @050 retire count then pc wnum wdata,
// @090 store count then address data, all records in program order
@000
3c018000 // lui   r1, 0x8000
34210010 // ori   r1, r1, 0x0010
2402ffff // addiu r2, r0, -1
00221821 // addu  r3, r1, r2
00012023 // subu  r4, r0, r1
0024282a // slt   r5, r1, r4
0024302b // sltu  r6, r1, r4
30478f0f // andi  r7, r2, 0x8f0f
00624026 // xor   r8, r3, r2
01044824 // and   r9, r8, r4
00220025 // or    r0, r1, r2
00005021 // addu  r10, r0, r0
ac230000 // sw    r3, 0(r1)
8c2b0000 // lw    r11, 0(r1)
016b6021 // addu  r12, r11, r11
8c0d0020 // lw    r13, 0x20(r0)
35ae0001 // ori   r14, r13, 1
11630002 // beq   r11, r3, +2
240f0bad // addiu r15 (squashed)
24100bad // addiu r16 (squashed)
14420002 // bne   r2, r2, +2
24110111 // addiu r17, r0, 0x111
16200002 // bne   r17, r0, +2
24120bad // addiu r18 (squashed)
24130bad // addiu r19 (squashed)
ac110024 // sw    r17, 0x24(r0)
8c140024 // lw    r20, 0x24(r0)
028ca821 // addu  r21, r20, r12
@040
00000000 01010101 02020202 03030303 deadbeef 05050505 06060606 07070707
12345678 cafef00d 0a0a0a0a 0b0b0b0b 0c0c0c0c 0d0d0d0d 0e0e0e0e 0f0f0f0f
@050
00000012
bfc00000 00000001 80000000
bfc00004 00000001 80000010
bfc00008 00000002 ffffffff
bfc0000c 00000003 8000000f
bfc00010 00000004 7ffffff0
bfc00014 00000005 00000001
bfc00018 00000006 00000000
bfc0001c 00000007 00008f0f
bfc00020 00000008 7ffffff0
bfc00024 00000009 7ffffff0
bfc0002c 0000000a 00000000
bfc00034 0000000b 8000000f
bfc00038 0000000c 0000001e
bfc0003c 0000000d 12345678
bfc00040 0000000e 12345679
bfc00054 00000011 00000111
bfc00068 00000014 00000111
bfc0006c 00000015 0000012f
@090
00000002
00000010 8000000f
00000024 00000111

// ==== tests/tb_mips_core.sv ====
`default_nettype none

module tb_mips_core import cpu_isa_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t reset_pc     = 32'hbfc00000;
    localparam int    imem_words   = 64;
    localparam int    dmem_words   = 256;
    localparam int    data_base    = 'h40;   // regions of the stimulus file
    localparam int    data_words   = 16;
    localparam int    retire_base  = 'h50;
    localparam int    store_base   = 'h90;
    localparam int    drain_cycles = 16;     // room for late extra records

    logic       clk;
    logic       resetn;
    word_t      inst_sram_rdata;
    word_t      data_sram_rdata;
    word_t      inst_sram_addr;
    logic [3:0] data_sram_wen;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t stim [256];
    word_t imem [imem_words];
    word_t dmem [dmem_words];
    int    retire_count;
    int    store_count;
    int    retire_idx;
    int    store_idx;
    int    errors;
    int    cycles;
    int    limit;

    clock_gen clock_inst (.clk(clk), .resetn(resetn));

    mips_core #(.reset_pc(reset_pc)) mips_core_inst (
        .clk(clk), .resetn(resetn),
        .inst_sram_rdata(inst_sram_rdata), .data_sram_rdata(data_sram_rdata),
        .inst_sram_addr(inst_sram_addr), .data_sram_wen(data_sram_wen),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    bind mips_core mips_core_assertions assertions_inst (
        .clk(clk), .resetn(resetn), .inst_sram_addr(inst_sram_addr),
        .data_sram_wen(data_sram_wen), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum)
    );

    ////////////////////
    // sram models, one cycle read latency
    function automatic word_t fetch_word(word_t addr);
        word_t offset;
        offset = addr - reset_pc;
        if (offset < 32'(imem_words * 4))
            return imem[offset[7:2]];
        return '0;   // past the program, decodes as invalid
    endfunction

    always @(posedge clk) begin
        inst_sram_rdata <= fetch_word(inst_sram_addr);
        data_sram_rdata <= dmem[data_sram_addr[9:2]];
        if (data_sram_wen == 4'hf)
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
    end

    ////////////////////
    // record checkers
    task automatic expect_word(input string name, input word_t expected, input word_t actual,
                               input int rec);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h, got %h (record %0d)", name, expected, actual, rec);
            errors++;
        end
    endtask

    task automatic score_retire();
        int base;
        if (retire_idx >= retire_count) begin
            $display("extra retire record: r%0d written at pc %h", debug_wb_rf_wnum, debug_wb_pc);
            errors++;
        end else begin
            base = retire_base + 1 + 3 * retire_idx;
            expect_word("debug_wb_pc", stim[base], debug_wb_pc, retire_idx);
            expect_word("debug_wb_rf_wnum", stim[base + 1], {27'b0, debug_wb_rf_wnum}, retire_idx);
            expect_word("debug_wb_rf_wdata", stim[base + 2], debug_wb_rf_wdata, retire_idx);
            retire_idx++;
        end
    endtask

    task automatic verify_store();
        int base;
        if (store_idx >= store_count) begin
            $display("extra store of %h to address %h", data_sram_wdata, data_sram_addr);
            errors++;
        end else begin
            base = store_base + 1 + 2 * store_idx;
            expect_word("data_sram_addr", stim[base], data_sram_addr, store_idx);
            expect_word("data_sram_wdata", stim[base + 1], data_sram_wdata, store_idx);
            store_idx++;
        end
    endtask

    // outputs have long settled by the falling edge
    always @(negedge clk) begin
        if (resetn && debug_wb_rf_wen != 4'h0)
            score_retire();
        if (resetn && data_sram_wen != 4'h0)
            verify_store();
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles: %0d of %0d retires, %0d of %0d stores, %0d errors",
                     cycles, retire_idx, retire_count, store_idx, store_count, errors);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        inst_sram_rdata <= '0;
        data_sram_rdata <= '0;
        for (int i = 0; i < 256; i++)
            stim[i] = '0;
        $readmemh("tests/program_stimulus.hex", stim);
        for (int i = 0; i < imem_words; i++)
            imem[i] = stim[i];
        // fill carries the byte address, initial data words go on top
        for (int i = 0; i < dmem_words; i++)
            dmem[i] <= {16'hd0d0, 16'(i * 4)};
        for (int i = 0; i < data_words; i++)
            dmem[i] <= stim[data_base + i];
        retire_count = stim[retire_base];
        store_count  = stim[store_base];
        limit        = 8 * (retire_count + store_count) + 100;

        wait (resetn === 1'b1);
        // first fetch comes from the reset vector
        if (inst_sram_addr !== reset_pc) begin
            $display("[FAIL] inst_sram_addr expected %h, got %h", reset_pc, inst_sram_addr);
            errors++;
        end
        while (retire_idx < retire_count || store_idx < store_count)
            @(posedge clk);
        repeat (drain_cycles) @(posedge clk);
        $display("%0d retire and %0d store records checked, %0d errors",
                 retire_idx, store_idx, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
